/* hdl/pmu_pkg.sv */
package pmu_pkg;

    localparam int INST_W       = 32;
    localparam int NUM_COUNTERS = 16;

    // rv32 major opcodes, bits [6:0]
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // order matches the class and class-cycle counter ids
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_CSR,
        CLS_LOAD,
        CLS_STORE,
        CLS_OTHER,
        CLS_IDLE    // nothing tracked
    } inst_class_t;

    // dump order
    typedef enum logic [3:0] {
        CNT_CYCLE,
        CNT_FETCHED,
        CNT_LSU_READ,
        CNT_ALU,
        CNT_BRANCH,
        CNT_CSR,
        CNT_LOAD,
        CNT_STORE,
        CNT_OTHER,
        CNT_ALU_CYC,
        CNT_BRANCH_CYC,
        CNT_CSR_CYC,
        CNT_LOAD_CYC,
        CNT_STORE_CYC,
        CNT_OTHER_CYC,
        CNT_FETCH_WAIT
    } counter_id_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_CLEAR,
        CMD_DUMP
    } pmu_cmd_t;

endpackage

/* hdl/inst_classifier.sv */
module inst_classifier import pmu_pkg::*; (
    input  logic [INST_W-1:0] fetch_rdata,
    output inst_class_t       fetch_class
);

    logic [6:0] opcode;

    assign opcode = fetch_rdata[6:0];

    // only the major opcode matters here, funct fields are ignored
    always_comb begin
        case (opcode)
            OP_OP_IMM, OP_OP, OP_LUI, OP_AUIPC: begin
                fetch_class = CLS_ALU;
            end
            OP_BRANCH, OP_JAL, OP_JALR: begin
                fetch_class = CLS_BRANCH;
            end
            OP_SYSTEM: begin
                fetch_class = CLS_CSR;
            end
            OP_LOAD: begin
                fetch_class = CLS_LOAD;
            end
            OP_STORE: begin
                fetch_class = CLS_STORE;
            end
            default: begin
                fetch_class = CLS_OTHER;    // fence, amo, custom, garbage
            end
        endcase
    end

endmodule

/* hdl/pmu_event_counters.sv */
module pmu_event_counters import pmu_pkg::*; #(
    parameter int CNT_W = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             count_en,
    input  logic             clear,
    input  logic             fetch_arvalid,
    input  logic             fetch_arready,
    input  logic             fetch_rvalid,
    input  logic             fetch_rready,
    input  inst_class_t      fetch_class,
    input  logic             lsu_rvalid,
    input  logic             lsu_rready,
    input  logic             ins_retire,
    input  counter_id_t      rd_id,
    output logic [CNT_W-1:0] rd_value
);

    logic [CNT_W-1:0] cnt [NUM_COUNTERS];

    inst_class_t cls_track;     // class of the instruction in flight
    logic        fetch_wait;    // ar accepted, r not yet seen

    logic fetch_ar_hs;
    logic fetch_r_hs;
    logic lsu_r_hs;

    counter_id_t cls_cnt_id;
    counter_id_t cls_cyc_id;

    assign fetch_ar_hs = fetch_arvalid & fetch_arready;
    assign fetch_r_hs  = fetch_rvalid & fetch_rready;
    assign lsu_r_hs    = lsu_rvalid & lsu_rready;

    // class ids are laid out in the same order as inst_class_t
    assign cls_cnt_id = counter_id_t'(4'(CNT_ALU) + 4'(fetch_class));
    assign cls_cyc_id = counter_id_t'(4'(CNT_ALU_CYC) + 4'(cls_track));

    // trackers run regardless of count_en
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cls_track  <= CLS_IDLE;
            fetch_wait <= 1'b0;
        end else begin
            if (fetch_r_hs) begin
                cls_track <= fetch_class;   // new fetch replaces old class
            end else if (ins_retire) begin
                cls_track <= CLS_IDLE;
            end

            if (fetch_ar_hs) begin
                fetch_wait <= 1'b1;
            end else if (fetch_r_hs) begin
                fetch_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                cnt[i] <= '0;
            end
        end else if (count_en) begin
            cnt[CNT_CYCLE] <= cnt[CNT_CYCLE] + 1'b1;

            if (fetch_r_hs) begin
                cnt[CNT_FETCHED] <= cnt[CNT_FETCHED] + 1'b1;
                cnt[cls_cnt_id]  <= cnt[cls_cnt_id] + 1'b1;
            end

            if (lsu_r_hs) begin
                cnt[CNT_LSU_READ] <= cnt[CNT_LSU_READ] + 1'b1;
            end

            if (cls_track != CLS_IDLE) begin
                cnt[cls_cyc_id] <= cnt[cls_cyc_id] + 1'b1;
            end

            if (fetch_wait) begin
                cnt[CNT_FETCH_WAIT] <= cnt[CNT_FETCH_WAIT] + 1'b1;
            end
        end
    end

    assign rd_value = cnt[rd_id];   // read port for the report walker

endmodule

/* hdl/pmu_ctrl_regs.sv */
module pmu_ctrl_regs import pmu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  pmu_cmd_t cmd,
    input  logic     dump_busy,
    output logic     count_en,
    output logic     clear,
    output logic     dump_start
);

    logic run;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run   <= 1'b0;
            clear <= 1'b0;
        end else begin
            clear <= cmd_valid && (cmd == CMD_CLEAR);   // one cycle pulse

            if (cmd_valid) begin
                case (cmd)
                    CMD_START: begin
                        run <= 1'b1;
                    end
                    CMD_STOP: begin
                        run <= 1'b0;
                    end
                    default: begin
                        run <= run;
                    end
                endcase
            end
        end
    end

    // second dump while one is running is dropped
    assign dump_start = cmd_valid && (cmd == CMD_DUMP) && !dump_busy;

    // freeze during dump so all words are one snapshot
    assign count_en = run && !dump_busy;

endmodule

/* hdl/pmu_report_tx.sv */
module pmu_report_tx import pmu_pkg::*; #(
    parameter int CNT_W       = 64,
    parameter int RPT_CREDITS = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             dump_start,
    input  logic [CNT_W-1:0] rd_value,
    input  logic             rpt_credit_return,
    output logic             dump_busy,
    output counter_id_t      rd_id,
    output logic             rpt_valid,
    output counter_id_t      rpt_id,
    output logic [CNT_W-1:0] rpt_value
);

    localparam int CRD_W = $clog2(RPT_CREDITS + 1);

    logic [CRD_W-1:0] credits;
    logic [4:0]       idx;      // 0..16, 16 means every word issued
    logic             send;

    assign rd_id = counter_id_t'(idx[3:0]);
    assign send  = dump_busy && !idx[4] && (credits != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dump_busy <= 1'b0;
            idx       <= '0;
            rpt_valid <= 1'b0;
        end else begin
            rpt_valid <= send;

            if (dump_start) begin
                dump_busy <= 1'b1;
                idx       <= '0;
            end else if (rpt_valid && (rpt_id == CNT_FETCH_WAIT)) begin
                dump_busy <= 1'b0;  // last word is on the channel
            end

            if (send) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (send) begin
            rpt_id    <= rd_id;
            rpt_value <= rd_value;
        end
    end

    // send and return in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CRD_W'(RPT_CREDITS);
        end else begin
            case ({send, rpt_credit_return})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

endmodule

/* hdl/pmu_top.sv */
module pmu_top import pmu_pkg::*; #(
    parameter int CNT_W       = 64,
    parameter int RPT_CREDITS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_arvalid,
    input  logic              fetch_arready,
    input  logic              fetch_rvalid,
    input  logic              fetch_rready,
    input  logic [INST_W-1:0] fetch_rdata,
    input  logic              lsu_rvalid,
    input  logic              lsu_rready,
    input  logic              ins_retire,
    input  logic              cmd_valid,
    input  pmu_cmd_t          cmd,
    output logic              rpt_valid,
    output counter_id_t       rpt_id,
    output logic [CNT_W-1:0]  rpt_value,
    input  logic              rpt_credit_return
);

    logic             count_en;
    logic             clear;
    logic             dump_start;
    logic             dump_busy;
    counter_id_t      rd_id;
    logic [CNT_W-1:0] rd_value;
    inst_class_t      fetch_class;

    inst_classifier i_inst_classifier (
        .fetch_rdata (fetch_rdata),
        .fetch_class (fetch_class)
    );

    pmu_event_counters #(
        .CNT_W (CNT_W)
    ) i_pmu_event_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .count_en      (count_en),
        .clear         (clear),
        .fetch_arvalid (fetch_arvalid),
        .fetch_arready (fetch_arready),
        .fetch_rvalid  (fetch_rvalid),
        .fetch_rready  (fetch_rready),
        .fetch_class   (fetch_class),
        .lsu_rvalid    (lsu_rvalid),
        .lsu_rready    (lsu_rready),
        .ins_retire    (ins_retire),
        .rd_id         (rd_id),
        .rd_value      (rd_value)
    );

    pmu_ctrl_regs i_pmu_ctrl_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .dump_busy  (dump_busy),
        .count_en   (count_en),
        .clear      (clear),
        .dump_start (dump_start)
    );

    pmu_report_tx #(
        .CNT_W       (CNT_W),
        .RPT_CREDITS (RPT_CREDITS)
    ) i_pmu_report_tx (
        .clk               (clk),
        .rst_n             (rst_n),
        .dump_start        (dump_start),
        .rd_value          (rd_value),
        .rpt_credit_return (rpt_credit_return),
        .dump_busy         (dump_busy),
        .rd_id             (rd_id),
        .rpt_valid         (rpt_valid),
        .rpt_id            (rpt_id),
        .rpt_value         (rpt_value)
    );

endmodule

/* verif/tb_pmu_top.sv */
module tb_pmu_top import pmu_pkg::*; ();

    localparam int CNT_W       = 64;
    localparam int RPT_CREDITS = 4;
    localparam int WAIT_MAX    = 400;   // cycles allowed for one dump

    logic              clk = 1'b0;
    logic              rst_n;
    logic              fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
    logic [INST_W-1:0] fetch_rdata;
    logic              lsu_rvalid, lsu_rready, ins_retire, cmd_valid;
    pmu_cmd_t          cmd;
    logic              rpt_valid;
    counter_id_t       rpt_id;
    logic [CNT_W-1:0]  rpt_value;
    logic              rpt_credit_return;

    // reference model
    logic [CNT_W-1:0] m_cnt  [NUM_COUNTERS];
    logic [CNT_W-1:0] snap   [NUM_COUNTERS];    // model values at the dump edge
    logic [CNT_W-1:0] rx_val [NUM_COUNTERS];
    inst_class_t      m_cls;
    logic             m_wait, m_run, m_clear, m_busy, m_last;

    int   seed = 29;
    int   outstanding;  // words received and not yet credited back
    int   words_got;
    logic collecting;

    pmu_top #(
        .CNT_W       (CNT_W),
        .RPT_CREDITS (RPT_CREDITS)
    ) i_pmu_top (.*);

    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_id(input counter_id_t got, input counter_id_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: report id %0d, expected %s",
                               $time, got, exp.name()));
        end
    endtask

    task automatic check_word(input counter_id_t id, input logic [CNT_W-1:0] got,
                              input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                               $time, id.name(), got, exp));
        end
    endtask

    task automatic check_credit(input int words);
        if (words > RPT_CREDITS) begin
            fail_now($sformatf("Mismatch at %0t: %0d words outstanding, only %0d credits",
                               $time, words, RPT_CREDITS));
        end
    endtask

    function automatic inst_class_t class_of(input logic [6:0] op);
        case (op)
            OP_OP_IMM, OP_OP, OP_LUI, OP_AUIPC: return CLS_ALU;
            OP_BRANCH, OP_JAL, OP_JALR:         return CLS_BRANCH;
            OP_SYSTEM:                          return CLS_CSR;
            OP_LOAD:                            return CLS_LOAD;
            OP_STORE:                           return CLS_STORE;
            default:                            return CLS_OTHER;
        endcase
    endfunction

    // one clock edge of the counter and tracker rules
    task automatic model_edge();
        logic        ar_hs;
        logic        r_hs;
        logic        l_hs;
        logic        en;
        inst_class_t cls;
        ar_hs = fetch_arvalid && fetch_arready;
        r_hs  = fetch_rvalid && fetch_rready;
        l_hs  = lsu_rvalid && lsu_rready;
        en    = m_run && !m_busy;   // frozen during dump
        cls   = class_of(fetch_rdata[6:0]);
        if (m_clear) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                m_cnt[i] = '0;
            end
        end else if (en) begin
            m_cnt[CNT_CYCLE] = m_cnt[CNT_CYCLE] + 1;
            if (r_hs) begin
                m_cnt[CNT_FETCHED] = m_cnt[CNT_FETCHED] + 1;
                m_cnt[int'(CNT_ALU) + int'(cls)] = m_cnt[int'(CNT_ALU) + int'(cls)] + 1;
            end
            if (l_hs) begin
                m_cnt[CNT_LSU_READ] = m_cnt[CNT_LSU_READ] + 1;
            end
            if (m_cls != CLS_IDLE) begin
                m_cnt[int'(CNT_ALU_CYC) + int'(m_cls)] =
                    m_cnt[int'(CNT_ALU_CYC) + int'(m_cls)] + 1;
            end
            if (m_wait) begin
                m_cnt[CNT_FETCH_WAIT] = m_cnt[CNT_FETCH_WAIT] + 1;
            end
        end
        if (r_hs) begin
            m_cls = cls;
        end else if (ins_retire) begin
            m_cls = CLS_IDLE;
        end
        if (ar_hs) begin
            m_wait = 1'b1;
        end else if (r_hs) begin
            m_wait = 1'b0;
        end
        m_clear = cmd_valid && (cmd == CMD_CLEAR);
        if (cmd_valid && (cmd == CMD_START)) begin
            m_run = 1'b1;
        end else if (cmd_valid && (cmd == CMD_STOP)) begin
            m_run = 1'b0;
        end
        if (cmd_valid && (cmd == CMD_DUMP) && !m_busy) begin
            m_busy = 1'b1;
        end else if (m_last) begin
            m_busy = 1'b0;  // edge after the last word
            m_last = 1'b0;
        end
    endtask

    // edge, model step, then sample and drive one step after the edge
    task automatic run_cycle();
        @(posedge clk);
        model_edge();
        #1;
        if (rpt_valid === 1'b1) begin
            if (!collecting || words_got >= NUM_COUNTERS) begin
                fail_now($sformatf("report word seen at %0t while no dump was running", $time));
            end
            check_id(rpt_id, counter_id_t'(words_got));
            check_word(rpt_id, rpt_value, snap[words_got]);
            rx_val[words_got] = rpt_value;
            words_got++;
            outstanding++;
            check_credit(outstanding);
            if (words_got == NUM_COUNTERS) begin
                m_last = 1'b1;
            end
        end
        rpt_credit_return = 1'b0;
        if (outstanding > 0 && ($random(seed) & 3) == 0) begin
            rpt_credit_return = 1'b1;   // sparse return
            outstanding--;
        end
    endtask

    task automatic set_idle();
        fetch_arvalid = 1'b0;
        fetch_arready = 1'b0;
        fetch_rvalid  = 1'b0;
        fetch_rready  = 1'b0;
        fetch_rdata   = '0;
        lsu_rvalid    = 1'b0;
        lsu_rready    = 1'b0;
        ins_retire    = 1'b0;
    endtask

    task automatic run_dump(input int dup, input logic [CNT_W-1:0] exp_fetched,
                            input logic [CNT_W-1:0] exp_lsu);
        int cyc;
        set_idle();
        collecting = 1'b1;
        words_got  = 0;
        cmd_valid  = 1'b1;
        cmd        = CMD_DUMP;
        run_cycle();
        snap      = m_cnt;
        cmd_valid = 1'b0;
        cyc       = 0;
        while (words_got < NUM_COUNTERS) begin
            cyc++;
            if (cyc > WAIT_MAX) begin
                fail_now("timeout, the dump did not deliver all sixteen words");
            end
            cmd_valid = (cyc == dup);   // extra DUMP while busy
            run_cycle();
        end
        cmd_valid  = 1'b0;
        collecting = 1'b0;
        run_cycle();
        check_word(CNT_FETCHED, rx_val[CNT_FETCHED], exp_fetched);
        check_word(CNT_LSU_READ, rx_val[CNT_LSU_READ], exp_lsu);
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [11];
        rst_n = 1'b0;
        set_idle();
        cmd_valid         = 1'b0;
        cmd               = CMD_START;
        rpt_credit_return = 1'b0;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            m_cnt[i] = '0;
        end
        m_cls       = CLS_IDLE;
        m_wait      = 1'b0;
        m_run       = 1'b0;
        m_clear     = 1'b0;
        m_busy      = 1'b0;
        m_last      = 1'b0;
        outstanding = 0;
        words_got   = 0;
        collecting  = 1'b0;
        fd = $fopen("verif/pmu_stimulus.txt", "r");
        if (fd == 0) begin
            fail_now("could not open verif/pmu_stimulus.txt");
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "C") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (n != 11) begin
                    fail_now({"cycle line has too few fields: ", line});
                end
                for (int c = 0; c < f[0]; c++) begin
                    fetch_arvalid = f[1][0];
                    fetch_arready = f[2][0];
                    fetch_rvalid  = f[3][0];
                    fetch_rready  = f[4][0];
                    fetch_rdata   = f[5];
                    lsu_rvalid    = f[6][0];
                    lsu_rready    = f[7][0];
                    ins_retire    = f[8][0];
                    cmd_valid     = (c == 0) && f[9][0];    // command on first cycle only
                    cmd           = pmu_cmd_t'(f[10][1:0]);
                    run_cycle();
                end
            end else if (line[0] == "D") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", f[0], f[1], f[2]);
                if (n != 3) begin
                    fail_now({"dump line has too few fields: ", line});
                end
                run_dump(f[0], f[1], f[2]);
            end else begin
                fail_now({"unknown line kind in stimulus file: ", line});
            end
        end
        $fclose(fd);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verif/pmu_stimulus.txt */
# C rep arvalid arready rvalid rready rdata lsu_rvalid lsu_rready retire cmd_valid cmd
# D dup_cycle expected_fetched expected_lsu_reads   (hex, dup_cycle 0 means no extra DUMP)
C 1 0 0 0 0 00000000 0 0 0 1 0  start
C 1 1 1 0 0 00000000 0 0 0 0 0  ar handshake
C 2 1 0 1 0 00100093 0 0 0 0 0  no handshake, fetch wait runs
C 1 0 0 1 1 00100093 0 0 0 0 0  addi
C 1 0 0 1 1 00208463 1 1 0 0 0  beq replaces tracked alu
C 3 0 0 0 0 00000000 0 0 0 0 0
C 1 0 0 0 0 00000000 0 0 1 0 0  retire
C 1 1 1 1 1 30002573 1 1 0 0 0  csrrs with ar and r together
C 2 0 0 1 1 0000a103 0 0 1 0 0  lw twice, fetch wins over retire
C 1 0 0 1 1 0020a023 1 1 1 0 0  sw
C 1 0 0 1 1 0ff0000f 0 0 0 0 0  fence
C 1 0 0 1 1 002081b3 0 1 0 0 0  add
C 1 0 0 1 1 000012b7 1 0 0 0 0  lui
C 1 0 0 1 1 00000317 0 0 0 0 0  auipc
C 1 0 0 1 1 0080006f 0 0 0 0 0  jal
C 1 0 0 1 1 000080e7 1 1 1 0 0  jalr
C 1 0 0 0 0 00000000 0 0 1 0 0  retire
D 0 c 4
C 1 0 0 0 0 00000000 0 0 0 1 1  stop
C 1 1 1 0 0 00000000 0 0 0 0 0  trackers move while stopped
C 2 0 0 1 1 00100093 1 1 0 0 0
C 1 0 0 0 0 00000000 0 0 0 1 0  start, alu still tracked
C 4 0 0 0 0 00000000 0 0 0 0 0
D 0 c 4
C 1 0 0 0 0 00000000 0 0 0 1 2  clear
C 1 0 0 1 1 0020a023 1 1 0 0 0  lost to the clear
C 1 0 0 1 1 0000a103 1 1 1 0 0
C 2 0 0 0 0 00000000 0 0 0 0 0
D 3 1 1
C 1 0 0 0 0 00000000 0 0 0 1 1  stop
D 0 1 1
D 0 1 1
C 6 0 0 0 0 00000000 0 0 0 0 0

/* src.f */
hdl/pmu_pkg.sv
hdl/inst_classifier.sv
hdl/pmu_event_counters.sv
hdl/pmu_ctrl_regs.sv
hdl/pmu_report_tx.sv
hdl/pmu_top.sv
verif/tb_pmu_top.sv
